// File: src.f
mem_map_pkg.sv
cpu_mem_pkg.sv
store_align.sv
mem_decode.sv
sync_ram.sv
bios_rom.sv
io_counters.sv
load_align.sv
mem_subsystem.sv
mem_subsystem_assert.sv
tb_mem_subsystem.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_mem_subsystem -f src.f

result=$(./obj_dir/Vtb_mem_subsystem 2>&1 || true)
printf '%s\n' "$result"
grep -qx 'all tests passed' <<< "$result"

// File: tb_mem_subsystem.sv
`default_nettype none

module tb_mem_subsystem
	import cpu_mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [1:0] {k_idle, k_load, k_store} kind_t;

	typedef struct packed {
		logic [2:0]  test;
		logic [31:0] fetch_pc;
		kind_t       kind;
		logic [31:0] addr;
		mem_width_t  width;
		logic [31:0] wdata;
		logic [31:0] pc;
		logic        retired;
		logic        chk_load;
		logic        chk_fetch;
	} row_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] fetch_pc;
	mem_req_t    req;
	logic        instr_retired;
	logic [31:0] fetch_inst;
	logic [31:0] load_data;

	row_t        rows[$];
	logic [7:0]  mem_model [int]; // Key is space * 4096 + byte address.
	logic [31:0] rom_model [0:15];
	logic [31:0] lfsr;
	logic [31:0] ref_cycles;
	logic [31:0] ref_instr;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	int          checks;
	logic        stalled;

	mem_subsystem dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.fetch_pc      (fetch_pc),
		.req           (req),
		.instr_retired (instr_retired),
		.fetch_inst    (fetch_inst),
		.load_data     (load_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h8020_0003; // Taps 32, 22, 2, 1.
		return b;
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++)
			w = {w[30:0], lfsr_bit()};
		return w;
	endfunction

	task automatic push_row(input logic [2:0] t, input logic [31:0] fpc, input kind_t kind,
			input logic [31:0] addr, input mem_width_t width, input logic [31:0] pc,
			input logic retired, input logic chk_load, input logic chk_fetch);
		row_t        r;
		logic [31:0] d;
		d = (kind == k_store) ? rand_word() : 32'h0;
		r = '{t, fpc, kind, addr, width, d, pc, retired, chk_load, chk_fetch};
		rows.push_back(r);
	endtask

	task automatic load_step(input logic [2:0] t, input logic [31:0] a, input mem_width_t w);
		push_row(t, 32'h4000_0000, k_load, a, w, 32'h0, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic store_step(input logic [2:0] t, input logic [31:0] a, input mem_width_t w,
			input logic [31:0] pc);
		push_row(t, 32'h4000_0000, k_store, a, w, pc, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic fetch_step(input logic [2:0] t, input logic [31:0] fpc);
		push_row(t, fpc, k_idle, 32'h0, w_word, 32'h0, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic build_table();
		logic [31:0] base;
		for (int b = 0; b < 2; b++) begin
			base = 32'h1000_0020 + b * 16;
			store_step(1, base, w_word, 32'h2000_0040);
			store_step(1, base + 1, w_byte, 32'h2000_0040);
			store_step(1, base + 2, w_half, 32'h2000_0040);
			for (int o = 0; o < 4; o++) begin
				load_step(1, base + o, w_byte);
				load_step(1, base + o, w_byte_u);
			end
			for (int o = 0; o < 4; o += 2) begin
				load_step(1, base + o, w_half);
				load_step(1, base + o, w_half_u);
			end
			load_step(1, base, w_word);
		end
		store_step(2, 32'h2000_0100, w_word, 32'h4000_0010);
		store_step(2, 32'h2000_0108, w_word, 32'h4000_0010);
		fetch_step(2, 32'h2000_0100);
		store_step(2, 32'h2000_0100, w_word, 32'h2000_0040); // Dropped since pc is outside the boot ROM.
		store_step(2, 32'h3000_0104, w_word, 32'h4000_0020);
		store_step(2, 32'h3000_0108, w_word, 32'h1000_0000);
		store_step(2, 32'h2000_0102, w_half, 32'h4000_0000);
		fetch_step(2, 32'h2000_0100);
		fetch_step(2, 32'h2000_0104);
		fetch_step(2, 32'h2000_0108);
		load_step(2, 32'h1000_0104, w_word);
		load_step(2, 32'h3000_0108, w_word);
		for (int i = 0; i < 16; i += 5)
			fetch_step(3, 32'h4000_0000 + i * 4);
		load_step(3, 32'h4000_0014, w_word);
		load_step(3, 32'h4000_003d, w_byte);
		load_step(3, 32'h4000_0032, w_half_u);
		load_step(3, 32'h4000_002e, w_half);
		store_step(3, 32'h4000_0014, w_word, 32'h4000_0000);
		load_step(3, 32'h4000_0014, w_word);
		fetch_step(3, 32'h4000_0014);
		load_step(4, 32'h8000_0010, w_word);
		push_row(4, 32'h4000_0000, k_idle, 32'h0, w_word, 32'h0, 1'b1, 1'b0, 1'b0);
		push_row(4, 32'h4000_0000, k_idle, 32'h0, w_word, 32'h0, 1'b1, 1'b0, 1'b0);
		load_step(4, 32'h8000_0014, w_word);
		push_row(4, 32'h4000_0000, k_load, 32'h8000_0010, w_word, 32'h0, 1'b1, 1'b1, 1'b0);
		load_step(4, 32'h8000_0014, w_word);
		store_step(4, 32'h8000_0018, w_word, 32'h4000_0000);
		load_step(4, 32'h8000_0010, w_word);
		load_step(4, 32'h8000_0014, w_word);
		load_step(4, 32'h8000_0010, w_word);
		load_step(4, 32'h8000_0000, w_word);
		store_step(5, 32'h1000_0040, w_word, 32'h2000_0040);
		store_step(5, 32'h0000_0040, w_word, 32'h4000_0000);
		store_step(5, 32'h5000_0040, w_word, 32'h4000_0000);
		store_step(5, 32'hf000_0040, w_word, 32'h4000_0000);
		load_step(5, 32'h1000_0040, w_word);
		load_step(5, 32'h0000_0040, w_word);
		load_step(5, 32'h5000_0040, w_word);
		load_step(5, 32'hf000_0040, w_byte);
	endtask

	function automatic int byte_key(input logic space, input logic [31:0] a);
		return (space ? 4096 : 0) + int'(a[11:0]);
	endfunction

	function automatic logic [31:0] model_word(input logic space, input logic [31:0] a);
		logic [31:0] w;
		int          k;
		w = '0;
		for (int i = 0; i < 4; i++) begin
			k = byte_key(space, {a[31:2], 2'b00}) + i;
			if (mem_model.exists(k))
				w[8*i +: 8] = mem_model[k];
		end
		return w;
	endfunction

	task automatic apply_store(input row_t r);
		logic boot;
		int   size;
		boot = (r.pc[31:28] == 4'h4);
		size = (r.width == w_word) ? 4 : (r.width == w_half || r.width == w_half_u) ? 2 : 1;
		for (int i = 0; i < size; i++) begin
			if (r.addr[31:28] == 4'h1 || r.addr[31:28] == 4'h3)
				mem_model[byte_key(1'b0, r.addr) + i] = r.wdata[8*i +: 8];
			if ((r.addr[31:28] == 4'h2 || r.addr[31:28] == 4'h3) && boot)
				mem_model[byte_key(1'b1, r.addr) + i] = r.wdata[8*i +: 8];
		end
	endtask

	function automatic logic [31:0] expect_load(input row_t r);
		logic [31:0] w;
		logic [31:0] s;
		logic [31:0] e;
		case (r.addr[31:28])
			4'h1, 4'h3: w = model_word(1'b0, r.addr);
			4'h4:       w = rom_model[r.addr[5:2]];
			4'h8:       w = (r.addr[27:0] == 28'h10) ? ref_cycles :
				(r.addr[27:0] == 28'h14) ? ref_instr : 32'h0;
			default:    w = '0;
		endcase
		s = w >> (8 * r.addr[1:0]);
		case (r.width)
			w_byte:   e = 32'($signed(s[7:0]));
			w_half:   e = 32'($signed(s[15:0]));
			w_byte_u: e = 32'(s[7:0]);
			w_half_u: e = 32'(s[15:0]);
			default:  e = s;
		endcase
		return e;
	endfunction

	function automatic logic [31:0] expect_fetch(input logic [31:0] pc);
		if (pc[31:28] == 4'h4)
			return rom_model[pc[5:2]];
		return model_word(1'b1, pc);
	endfunction

	function automatic string test_name(input logic [2:0] t);
		case (t)
			3'd0:    return "reset";
			3'd1:    return "dmem load/store";
			3'd2:    return "imem patch";
			3'd3:    return "boot rom";
			3'd4:    return "io counters";
			default: return "unmapped regions";
		endcase
	endfunction

	task automatic finish_test(input logic [2:0] t);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0d %s: ok", t, test_name(t));
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", t, test_name(t), test_errors);
		end
		test_errors = 0;
	endtask

	// Polls clk between its edges and lands 1 ns after a rising edge.
	task automatic next_cycle();
		logic saw_low;
		int   waited;
		saw_low = (clk == 1'b0);
		waited = 0;
		while (!(saw_low && clk == 1'b1) && waited < 8) begin
			#2;
			waited++;
			if (clk == 1'b0)
				saw_low = 1'b1;
		end
		if (!(saw_low && clk == 1'b1)) begin
			$display("Clock stopped, no rising edge within %0d ns", 2 * waited);
			stalled = 1'b1;
		end
	endtask

	task automatic drive_row(input row_t r);
		fetch_pc = r.fetch_pc;
		req.load = (r.kind == k_load);
		req.store = (r.kind == k_store);
		req.addr = r.addr;
		req.width = r.width;
		req.wdata = r.wdata;
		req.pc = r.pc;
		instr_retired = r.retired;
	endtask

	initial begin
		row_t        r;
		logic [31:0] exp_load;
		logic [31:0] exp_fetch;

		rst_n = 1'b0;
		fetch_pc = 32'h4000_0000;
		req = '0;
		instr_retired = 1'b0;
		lfsr = 32'h717a_038a;
		ref_cycles = '0;
		ref_instr = '0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		checks = 0;
		stalled = 1'b0;
		rom_model = '{32'h0000_0013, 32'h1000_00b7, 32'h2000_0137, 32'h0000_0193,
			32'h4000_0237, 32'h0000_a283, 32'h0051_2023, 32'h0040_8093,
			32'h0041_0113, 32'h0011_8193, 32'h0400_0313, 32'hfe61_c6e3,
			32'h2000_0067, 32'h0000_006f, 32'h0000_0013, 32'hdead_beef};
		build_table();
		#1;
		for (int c = 0; c < 5 && !stalled; c++)
			next_cycle();
		checks++;
		assert (load_data === 32'h0) else begin
			$display("Error: load_data after reset got %h, expected %h", load_data, 32'h0);
			test_errors++;
		end
		finish_test(3'd0);
		rst_n = 1'b1;

		for (int i = 0; i < rows.size() && !stalled; i++) begin
			r = rows[i];
			drive_row(r);
			exp_load = expect_load(r);
			exp_fetch = expect_fetch(r.fetch_pc);
			next_cycle();
			if (stalled)
				break;
			if (r.chk_load) begin
				checks++;
				assert (load_data === exp_load) else begin
					$display("Error: row %0d load_data got %h, expected %h",
						i, load_data, exp_load);
					test_errors++;
				end
			end
			if (r.chk_fetch) begin
				checks++;
				assert (fetch_inst === exp_fetch) else begin
					$display("Error: row %0d fetch_inst got %h, expected %h",
						i, fetch_inst, exp_fetch);
					test_errors++;
				end
			end
			// State moves at the edge that ended this row.
			if (r.kind == k_store)
				apply_store(r);
			if (r.kind == k_store && r.addr[31:28] == 4'h8 && r.addr[27:0] == 28'h18) begin
				ref_cycles = '0;
				ref_instr = '0;
			end else begin
				ref_cycles = ref_cycles + 32'd1;
				if (r.retired)
					ref_instr = ref_instr + 32'd1;
			end
			if (i == rows.size() - 1 || rows[i + 1].test != r.test)
				finish_test(r.test);
		end

		$display("tests run: %0d, failed: %0d, checks: %0d", tests_run, tests_failed, checks);
		if (tests_failed == 0 && !stalled)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: mem_subsystem_assert.sv
`default_nettype none

module mem_subsystem_assert
	import mem_map_pkg::*, cpu_mem_pkg::*;
(
	input wire logic       clk,
	input wire logic       rst_n,
	input wire mem_req_t   req,
	input wire logic [3:0] imem_we,
	input wire logic [3:0] dmem_we,
	input wire wb_ctl_t    wb
);

	timeunit 1ns;
	timeprecision 100ps;

	imem_we_boot_pc: assert property (@(posedge clk) disable iff (!rst_n)
		(imem_we != 4'b0000) |-> (req.pc[31:28] == reg_bios))
		else $error("imem write enabled with store pc outside the boot ROM");

	we_needs_store: assert property (@(posedge clk) disable iff (!rst_n)
		!req.store |-> (imem_we == 4'b0000 && dmem_we == 4'b0000))
		else $error("write enable active without a store");

	wb_idle_src: assert property (@(posedge clk) disable iff (!rst_n)
		!req.load |=> (wb.src == src_none))
		else $error("writeback source set after a cycle without a load");

endmodule

bind mem_decode mem_subsystem_assert assert0 (
	.clk     (clk),
	.rst_n   (rst_n),
	.req     (req),
	.imem_we (imem_we),
	.dmem_we (dmem_we),
	.wb      (wb)
);

`default_nettype wire

// File: mem_subsystem.sv
`default_nettype none

module mem_subsystem
	import mem_map_pkg::*, cpu_mem_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic [31:0] fetch_pc,
	input  wire mem_req_t    req,
	input  wire logic        instr_retired,
	output logic [31:0]      fetch_inst,
	output logic [31:0]      load_data
);

	mem_addr_u   fetch_addr;
	logic [3:0]  byte_mask;
	logic [31:0] wdata;
	logic [3:0]  imem_we;
	logic [3:0]  dmem_we;
	logic        io_we;
	logic        fetch_src_q;
	wb_ctl_t     wb;
	logic [31:0] imem_rdata;
	logic [31:0] dmem_rdata;
	logic [31:0] bios_data_a;
	logic [31:0] bios_data_b;
	logic [31:0] io_rdata;

	assign fetch_addr = fetch_pc;

	store_align store_align0 (
		.req       (req),
		.byte_mask (byte_mask),
		.wdata     (wdata)
	);

	mem_decode mem_decode0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.fetch_pc    (fetch_pc),
		.byte_mask   (byte_mask),
		.imem_we     (imem_we),
		.dmem_we     (dmem_we),
		.io_we       (io_we),
		.fetch_src_q (fetch_src_q),
		.wb          (wb)
	);

	sync_ram imem0 (
		.clk   (clk),
		.we    (imem_we),
		.waddr (req.addr.mem.word[word_idx_w-1:0]),
		.raddr (fetch_addr.mem.word[word_idx_w-1:0]),
		.wdata (wdata),
		.rdata (imem_rdata)
	);

	sync_ram dmem0 (
		.clk   (clk),
		.we    (dmem_we),
		.waddr (req.addr.mem.word[word_idx_w-1:0]),
		.raddr (req.addr.mem.word[word_idx_w-1:0]),
		.wdata (wdata),
		.rdata (dmem_rdata)
	);

	bios_rom bios_rom0 (
		.clk    (clk),
		.addr_a (fetch_addr.mem.word[bios_idx_w-1:0]),
		.addr_b (req.addr.mem.word[bios_idx_w-1:0]),
		.data_a (bios_data_a),
		.data_b (bios_data_b)
	);

	io_counters io_counters0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_retired (instr_retired),
		.io_we         (io_we),
		.req           (req),
		.rdata         (io_rdata)
	);

	load_align load_align0 (
		.wb        (wb),
		.dmem_data (dmem_rdata),
		.bios_data (bios_data_b),
		.io_data   (io_rdata),
		.load_data (load_data)
	);

	assign fetch_inst = fetch_src_q ? bios_data_a : imem_rdata; // Select lags fetch_pc by one.

endmodule

`default_nettype wire

// File: load_align.sv
`default_nettype none

module load_align
	import cpu_mem_pkg::*;
(
	input  wire wb_ctl_t     wb,
	input  wire logic [31:0] dmem_data,
	input  wire logic [31:0] bios_data,
	input  wire logic [31:0] io_data,
	output logic [31:0]      load_data
);

	logic [31:0] raw;
	logic [31:0] shifted;

	always_comb begin
		case (wb.src)
			src_dmem: raw = dmem_data;
			src_bios: raw = bios_data;
			src_io:   raw = io_data;
			default:  raw = '0;
		endcase
	end

	// Move the addressed byte down to lane 0.
	assign shifted = raw >> {wb.byte_ofs, 3'b000};

	always_comb begin
		case (wb.width)
			w_byte:   load_data = {{24{shifted[7]}}, shifted[7:0]};
			w_byte_u: load_data = {24'h00_0000, shifted[7:0]};
			w_half:   load_data = {{16{shifted[15]}}, shifted[15:0]};
			w_half_u: load_data = {16'h0000, shifted[15:0]};
			default:  load_data = shifted;
		endcase
	end

endmodule

`default_nettype wire

// File: io_counters.sv
`default_nettype none

module io_counters
	import mem_map_pkg::*, cpu_mem_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire logic     instr_retired,
	input  wire logic     io_we,
	input  wire mem_req_t req,
	output logic [31:0]   rdata
);

	logic [31:0] cycle_cnt;
	logic [31:0] instr_cnt;
	logic        clear;

	assign clear = io_we && (req.addr.map.offset == io_clear_ofs);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle_cnt <= '0;
			instr_cnt <= '0;
		end else if (clear) begin
			cycle_cnt <= '0; // Clear wins over both increments.
			instr_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + 32'd1;
			if (instr_retired)
				instr_cnt <= instr_cnt + 32'd1;
		end
	end

	// Captures the count from before this edge.
	always_ff @(posedge clk) begin
		case (req.addr.map.offset)
			io_cycle_ofs: rdata <= cycle_cnt;
			io_instr_ofs: rdata <= instr_cnt;
			default:      rdata <= '0;
		endcase
	end

endmodule

`default_nettype wire

// File: bios_rom.sv
`default_nettype none

module bios_rom
	import mem_map_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic [bios_idx_w-1:0] addr_a,
	input  wire logic [bios_idx_w-1:0] addr_b,
	output logic [31:0]                data_a,
	output logic [31:0]                data_b
);

	// Small copy loop from dmem into imem, then jump.
	function automatic logic [31:0] rom_word(input logic [bios_idx_w-1:0] idx);
		logic [31:0] w;
		case (idx)
			4'd0:    w = 32'h0000_0013;
			4'd1:    w = 32'h1000_00b7;
			4'd2:    w = 32'h2000_0137;
			4'd3:    w = 32'h0000_0193;
			4'd4:    w = 32'h4000_0237;
			4'd5:    w = 32'h0000_a283;
			4'd6:    w = 32'h0051_2023;
			4'd7:    w = 32'h0040_8093;
			4'd8:    w = 32'h0041_0113;
			4'd9:    w = 32'h0011_8193;
			4'd10:   w = 32'h0400_0313;
			4'd11:   w = 32'hfe61_c6e3;
			4'd12:   w = 32'h2000_0067;
			4'd13:   w = 32'h0000_006f; // Spin if the jump falls through.
			4'd14:   w = 32'h0000_0013;
			default: w = 32'hdead_beef;
		endcase
		return w;
	endfunction

	always_ff @(posedge clk) begin
		data_a <= rom_word(addr_a);
		data_b <= rom_word(addr_b);
	end

endmodule

`default_nettype wire

// File: sync_ram.sv
`default_nettype none

module sync_ram
	import mem_map_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic [3:0]            we,
	input  wire logic [word_idx_w-1:0] waddr,
	input  wire logic [word_idx_w-1:0] raddr,
	input  wire logic [31:0]           wdata,
	output logic [31:0]                rdata
);

	logic [31:0] mem [0:(1 << $bits(raddr)) - 1];

	// Byte lanes written independently.
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (we[i])
				mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
		end
	end

	// Read returns the old word on a same-cycle write.
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// File: mem_decode.sv
`default_nettype none

module mem_decode
	import mem_map_pkg::*, cpu_mem_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire mem_req_t    req,
	input  wire logic [31:0] fetch_pc,
	input  wire logic [3:0]  byte_mask,
	output logic [3:0]       imem_we,
	output logic [3:0]       dmem_we,
	output logic             io_we,
	output logic             fetch_src_q,
	output wb_ctl_t          wb
);

	mem_addr_u pc_addr;
	mem_addr_u fetch_addr;
	logic      pc_in_bios;
	logic      imem_en;
	logic      dmem_en;
	logic      io_en;
	logic      fetch_src;
	load_src_t load_src;

	assign pc_addr    = req.pc;
	assign fetch_addr = fetch_pc;
	assign pc_in_bios = (pc_addr.map.region == reg_bios); // Only boot code may patch imem.

	always_comb begin
		imem_en = 1'b0;
		dmem_en = 1'b0;
		io_en   = 1'b0;
		case (req.addr.map.region)
			reg_dmem: dmem_en = 1'b1;
			reg_imem: imem_en = pc_in_bios;
			reg_both: begin
				dmem_en = 1'b1;
				imem_en = pc_in_bios;
			end
			reg_io:   io_en = 1'b1;
			default:  ; // Unmapped stores are dropped.
		endcase
	end

	// Mask is already zero without a store.
	assign imem_we = imem_en ? byte_mask : 4'b0000;
	assign dmem_we = dmem_en ? byte_mask : 4'b0000;
	assign io_we   = io_en & req.store;

	always_comb begin
		load_src = src_none;
		if (req.load) begin
			case (req.addr.map.region)
				reg_dmem, reg_both: load_src = src_dmem;
				reg_bios:           load_src = src_bios;
				reg_io:             load_src = src_io;
				default:            load_src = src_none;
			endcase
		end
	end

	// Fetch outside BIOS goes to imem.
	assign fetch_src = (fetch_addr.map.region == reg_bios);

	// Line up selects with the RAM read latency.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb          <= '0;
			fetch_src_q <= 1'b0;
		end else begin
			wb.src      <= load_src;
			wb.width    <= req.width;
			wb.byte_ofs <= req.addr.mem.byte_ofs;
			fetch_src_q <= fetch_src;
		end
	end

endmodule

`default_nettype wire

// File: store_align.sv
`default_nettype none

module store_align
	import cpu_mem_pkg::*;
(
	input  wire mem_req_t req,
	output logic [3:0]    byte_mask,
	output logic [31:0]   wdata
);

	logic [3:0] base_mask;
	logic [1:0] ofs;

	assign ofs = req.addr.mem.byte_ofs;

	// Replicate the low lanes so any offset finds its data.
	always_comb begin
		case (req.width)
			w_byte, w_byte_u: begin
				base_mask = 4'b0001;
				wdata     = {4{req.wdata[7:0]}};
			end
			w_half, w_half_u: begin
				base_mask = 4'b0011;
				wdata     = {2{req.wdata[15:0]}};
			end
			default: begin
				base_mask = 4'b1111;
				wdata     = req.wdata;
			end
		endcase
	end

	always_comb begin
		byte_mask = 4'b0000;
		if (req.store)
			byte_mask = base_mask << ofs;
	end

endmodule

`default_nettype wire

// File: cpu_mem_pkg.sv
`default_nettype none

package cpu_mem_pkg;

	import mem_map_pkg::*;

	// Load/store funct3.
	typedef enum logic [2:0] {
		w_byte   = 3'b000,
		w_half   = 3'b001,
		w_word   = 3'b010,
		w_byte_u = 3'b100,
		w_half_u = 3'b101
	} mem_width_t;

	// None must stay zero, so reset gives a zero load.
	typedef enum logic [1:0] {
		src_none = 2'd0,
		src_dmem = 2'd1,
		src_bios = 2'd2,
		src_io   = 2'd3
	} load_src_t;

	typedef struct packed {
		logic        load;
		logic        store;
		mem_addr_u   addr;
		mem_width_t  width;
		logic [31:0] wdata;
		logic [31:0] pc; // PC of the store instruction.
	} mem_req_t;

	typedef struct packed {
		load_src_t  src;
		mem_width_t width;
		logic [1:0] byte_ofs;
	} wb_ctl_t;

endpackage

`default_nettype wire

// File: mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

	// Top address nibble selects the region.
	typedef enum logic [3:0] {
		reg_dmem = 4'b0001,
		reg_imem = 4'b0010,
		reg_both = 4'b0011, // Stores hit both RAMs and loads read dmem.
		reg_bios = 4'b0100,
		reg_io   = 4'b1000
	} region_t;

	localparam int dmem_words = 1024;
	localparam int imem_words = 1024;
	localparam int word_idx_w = $clog2((dmem_words > imem_words) ? dmem_words : imem_words);

	localparam int bios_words = 16;
	localparam int bios_idx_w = $clog2(bios_words);

	// Byte offsets inside the I/O region.
	localparam logic [27:0] io_cycle_ofs = 28'h10;
	localparam logic [27:0] io_instr_ofs = 28'h14;
	localparam logic [27:0] io_clear_ofs = 28'h18;

	typedef union packed {
		struct packed {
			region_t     region;
			logic [27:0] offset;
		} map;
		struct packed {
			logic [1:0]  unused;
			logic [27:0] word;
			logic [1:0]  byte_ofs;
		} mem;
	} mem_addr_u;

endpackage

`default_nettype wire
